//--- gps_pkg.sv
`default_nettype none

package gps_pkg;

	// fix input and the fields taken from it
	typedef logic [23:0] coord_t;      // .16
	typedef logic [11:0] lat_t;        // low bits of the latitude
	typedef logic [5:0]  delta_t;

	// cosine table geometry
	localparam int COS_DEPTH   = 128;
	localparam int COS_KEY_LSB = 48;

	typedef logic [$clog2(COS_DEPTH)-1:0] cos_addr_t;
	typedef logic [95:0] cos_word_t;
	typedef logic [27:0] cos_key_t;    // .32
	typedef logic [31:0] cos_val_t;    // .32
	typedef logic [63:0] cosine_t;     // .64

	// intermediate products
	typedef logic [16:0]  rad_prod_t;  // .32
	typedef logic [29:0]  sq_term_t;   // .64
	typedef logic [93:0]  lon_term_t;  // .128
	typedef logic [157:0] final_prod_t; // .192
	typedef logic [29:0]  haversine_t; // .64

	localparam logic [10:0] RAD_PER_UNIT = 11'h477; // pi/180, .16

	// brackets loaded before every search, entries 0 and 127
	localparam cos_key_t  COS_FIRST_KEY = 28'h7AE147A;
	localparam cos_val_t  COS_FIRST_VAL = 32'hF03CE5C7;
	localparam cos_key_t  COS_LAST_KEY  = 28'hAD6FA82;
	localparam cos_val_t  COS_LAST_VAL  = 32'hF14FA845;
	localparam cos_addr_t COS_LAST_ADDR = cos_addr_t'(COS_DEPTH - 1);
	localparam cos_addr_t COS_MID_ADDR  = 7'd63;

	typedef enum logic [1:0] {
		FIRST_IDLE,
		FIRST_WAIT,
		IDLE,
		BUSY
	} ctrl_state_e;

	// interpolator states carry a prefix, IDLE is taken by the control FSM
	typedef enum logic [2:0] {
		CI_IDLE,
		CI_FIND,
		CI_CALC1,
		CI_WAIT1,
		CI_CALC2,
		CI_WAIT2
	} interp_state_e;

endpackage

`default_nettype wire

//--- shift_add_mult.sv
`default_nettype none

module shift_add_mult #(
	parameter int multiplicand_size = 32,
	parameter int multiplier_size   = 32
) (
	input  wire                                          clk,
	input  wire                                          reset_n,
	input  wire                                          start,
	input  wire  [multiplicand_size-1:0]                 multiplicand,
	input  wire  [multiplier_size-1:0]                   multiplier,
	output logic                                         finish,
	output logic [multiplicand_size+multiplier_size-1:0] product
);

	logic                                         busy;
	logic [$clog2(multiplier_size)-1:0]           cnt;
	logic [multiplicand_size-1:0]                 mcand;
	logic [multiplicand_size+multiplier_size-1:0] acc;
	logic [multiplicand_size+multiplier_size-1:0] acc_next;
	logic [multiplicand_size:0]                   upper;
	logic                                         last;

	assign last = busy && (cnt == multiplier_size - 1);

	// low half holds the remaining multiplier bits
	always_comb begin
		upper = {1'b0, acc[multiplicand_size+multiplier_size-1:multiplier_size]};
		if (acc[0])
			upper = upper + {1'b0, mcand};
		acc_next = {upper, acc[multiplier_size-1:1]};
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			busy <= 1'b0;
		else if (!busy)
			busy <= start;
		else if (last)
			busy <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			mcand <= multiplicand; // sampled every idle cycle
			acc   <= {{multiplicand_size{1'b0}}, multiplier};
			cnt   <= '0;
		end else begin
			acc <= acc_next;
			cnt <= cnt + 1'b1;
		end
	end

	assign finish  = last;
	assign product = acc_next;

endmodule

`default_nettype wire

//--- restoring_div.sv
`default_nettype none

module restoring_div #(
	parameter int dividend_size = 64,
	parameter int divisor_size  = 32
) (
	input  wire                      clk,
	input  wire                      reset_n,
	input  wire                      start,
	input  wire  [dividend_size-1:0] dividend,
	input  wire  [divisor_size-1:0]  divisor,
	output logic                     finish,
	output logic [dividend_size-1:0] quotient
);

	logic                                   busy;
	logic [$clog2(dividend_size)-1:0]       cnt;
	logic [divisor_size-1:0]                dvsr;
	logic [divisor_size+dividend_size-1:0]  rq;   // remainder : quotient
	logic [divisor_size+dividend_size-1:0]  rq_next;
	logic [divisor_size:0]                  diff;
	logic                                   last;

	assign last = busy && (cnt == dividend_size - 1);

	// trial subtract, borrow means restore
	always_comb begin
		diff = rq[divisor_size+dividend_size-1:dividend_size-1] - {1'b0, dvsr};
		if (diff[divisor_size])
			rq_next = {rq[divisor_size+dividend_size-2:0], 1'b0};
		else
			rq_next = {diff[divisor_size-1:0], rq[dividend_size-2:0], 1'b1};
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			busy <= 1'b0;
		else if (!busy)
			busy <= start;
		else if (last)
			busy <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			dvsr <= divisor;
			rq   <= {{divisor_size{1'b0}}, dividend};
			cnt  <= '0;
		end else begin
			rq  <= rq_next;
			cnt <= cnt + 1'b1;
		end
	end

	assign finish   = last;
	assign quotient = rq_next[dividend_size-1:0];

endmodule

`default_nettype wire

//--- cos_interp.sv
`default_nettype none

module cos_interp import gps_pkg::*; (
	input  wire             clk,
	input  wire             reset_n,
	input  wire             start,
	input  wire lat_t       lat,
	input  wire cos_word_t  cos_data,
	output cos_addr_t       cos_addr,
	output logic            finish,
	output cosine_t         value
);

	interp_state_e state, state_next;
	cos_key_t      key, xl, xr, xl_next, xr_next;
	cos_val_t      yl, yr, yl_next, yr_next;
	cos_addr_t     lo, hi, lo_next, hi_next;
	cos_key_t      probe_key;
	cos_val_t      probe_val;
	logic [7:0]    addr_sum;
	logic          found;
	cos_key_t      span, offset;
	cos_val_t      rise;
	logic [18:0]   t1, t2;
	logic [17:0]   t3;
	logic [50:0]   t4, t4_product; // .64
	logic [36:0]   t5, t5_product; // .64
	logic          t4_finish, t5_finish, div_finish;
	logic [51:0]   num;
	logic [83:0]   quotient;

	assign probe_key = cos_data[COS_KEY_LSB +: $bits(cos_key_t)];
	assign probe_val = cos_data[$bits(cos_val_t)-1:0];

	// cos_addr always points at the middle of the current bracket
	always_comb begin
		lo_next = lo;
		hi_next = hi;
		xl_next = xl;
		xr_next = xr;
		yl_next = yl;
		yr_next = yr;
		if (key >= probe_key) begin
			lo_next = cos_addr;
			xl_next = probe_key;
			yl_next = probe_val;
		end else begin
			hi_next = cos_addr;
			xr_next = probe_key;
			yr_next = probe_val;
		end
	end

	assign addr_sum = {1'b0, lo_next} + {1'b0, hi_next};
	assign found    = (lo_next + cos_addr_t'(1) == hi_next);

	always_comb begin
		state_next = state;
		case (state)
			CI_IDLE:  if (start) state_next = CI_FIND;
			CI_FIND:  if (found) state_next = CI_CALC1;
			CI_CALC1: state_next = CI_WAIT1;
			CI_WAIT1: if (t4_finish) state_next = CI_CALC2;
			CI_CALC2: state_next = CI_WAIT2;
			CI_WAIT2: if (div_finish) state_next = CI_IDLE;
			default:  state_next = CI_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state    <= CI_IDLE;
			cos_addr <= COS_MID_ADDR;
		end else begin
			state <= state_next;
			if (state == CI_IDLE)
				cos_addr <= COS_MID_ADDR; // first probe
			else if (state == CI_FIND)
				cos_addr <= addr_sum[7:1];
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			CI_IDLE: begin
				key <= {lat, 16'b0};
				lo  <= '0;
				xl  <= COS_FIRST_KEY;
				yl  <= COS_FIRST_VAL;
				hi  <= COS_LAST_ADDR;
				xr  <= COS_LAST_KEY;
				yr  <= COS_LAST_VAL;
			end
			CI_FIND: begin
				lo <= lo_next;
				xl <= xl_next;
				yl <= yl_next;
				hi <= hi_next;
				xr <= xr_next;
				yr <= yr_next;
			end
			CI_WAIT1: begin
				if (t4_finish)
					t4 <= t4_product;
				if (t5_finish)
					t5 <= t5_product;
			end
			default: ;
		endcase
	end

	// y = (yl*t1 + t3*t2) / t1
	assign span   = xr - xl;
	assign offset = key - xl;
	assign rise   = yr - yl;
	assign t1     = span[18:0];
	assign t2     = offset[18:0];
	assign t3     = rise[17:0]; // modulo 2^18
	assign num    = {1'b0, t4} + {15'b0, t5};

	shift_add_mult #(.multiplicand_size(32), .multiplier_size(19)) base_mult (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (state == CI_CALC1),
		.multiplicand (yl),
		.multiplier   (t1),
		.finish       (t4_finish),
		.product      (t4_product)
	);

	shift_add_mult #(.multiplicand_size(18), .multiplier_size(19)) slope_mult (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (state == CI_CALC1),
		.multiplicand (t3),
		.multiplier   (t2),
		.finish       (t5_finish),
		.product      (t5_product)
	);

	restoring_div #(.dividend_size(84), .divisor_size(19)) interp_div (
		.clk      (clk),
		.reset_n  (reset_n),
		.start    (state == CI_CALC2),
		.dividend ({num, 32'b0}),
		.divisor  (t1),
		.finish   (div_finish),
		.quotient (quotient)
	);

	assign finish = (state == CI_WAIT2) && div_finish;
	assign value  = quotient[63:0];

endmodule

`default_nettype wire

//--- gps_dist_ctrl.sv
`default_nettype none

module gps_dist_ctrl import gps_pkg::*; (
	input  wire             clk,
	input  wire             reset_n,
	input  wire             den,
	input  wire coord_t     lat_in,
	input  wire coord_t     lon_in,
	input  wire             cos_finish,
	input  wire cosine_t    cos_value,
	input  wire             lat_sq_finish,
	input  wire sq_term_t   lat_sq,
	input  wire             lon_cos_a_finish,
	input  wire lon_term_t  lon_cos_a,
	output logic            cos_start,
	output lat_t            cos_lat,
	output logic            delta_start,
	output delta_t          lat_delta,
	output delta_t          lon_delta,
	output cosine_t         cos_a,
	output logic            valid,
	output haversine_t      a
);

	ctrl_state_e state, state_next;
	lat_t        lat_prev, lat_diff;
	coord_t      lon_prev, lon_diff;
	logic        accept;
	sq_term_t    lat_sq_q;
	lon_term_t   lon_term;
	logic        final_start, final_finish;
	final_prod_t final_product;

	assign accept      = den && (state == FIRST_IDLE || state == IDLE);
	assign cos_start   = accept;
	assign delta_start = den && (state == IDLE); // no deltas for the first fix
	assign cos_lat     = lat_in[$bits(lat_t)-1:0];

	// absolute differences to the previous fix
	assign lat_diff  = (lat_prev >= cos_lat) ? lat_prev - cos_lat : cos_lat - lat_prev;
	assign lon_diff  = (lon_prev >= lon_in) ? lon_prev - lon_in : lon_in - lon_prev;
	assign lat_delta = lat_diff[$bits(delta_t)-1:0];
	assign lon_delta = lon_diff[$bits(delta_t)-1:0];

	always_comb begin
		state_next = state;
		case (state)
			FIRST_IDLE: if (den) state_next = FIRST_WAIT;
			FIRST_WAIT: if (cos_finish) state_next = IDLE;
			IDLE:       if (den) state_next = BUSY;
			BUSY:       if (final_finish) state_next = IDLE;
			default:    state_next = FIRST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= FIRST_IDLE;
			valid <= 1'b0;
		end else begin
			state <= state_next;
			valid <= final_finish;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			lat_prev <= cos_lat; // new fix becomes the reference
			lon_prev <= lon_in;
		end
		if (cos_finish)
			cos_a <= cos_value;
		if (lat_sq_finish)
			lat_sq_q <= lat_sq;
		if (lon_cos_a_finish)
			lon_term <= lon_cos_a;
		if (final_finish)
			a <= lat_sq_q + final_product[$bits(final_prod_t)-1 -: $bits(haversine_t)];
	end

	// cos(latB) goes straight in, lon term already captured by now
	assign final_start = (state == BUSY) && cos_finish;

	shift_add_mult #(
		.multiplicand_size ($bits(cosine_t)),
		.multiplier_size   ($bits(lon_term_t))
	) final_mult (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (final_start),
		.multiplicand (cos_value),
		.multiplier   (lon_term),
		.finish       (final_finish),
		.product      (final_product)
	);

endmodule

`default_nettype wire

//--- gps_dist_top.sv
`default_nettype none

module gps_dist_top import gps_pkg::*; (
	input  wire             clk,
	input  wire             reset_n,
	input  wire             den,
	input  wire coord_t     lat_in,
	input  wire coord_t     lon_in,
	output cos_addr_t       cos_addr,
	input  wire cos_word_t  cos_data,
	output logic            valid,
	output haversine_t      a
);

	logic      cos_start, cos_finish;
	lat_t      cos_lat;
	cosine_t   cos_value, cos_a;
	logic      delta_start;
	delta_t    lat_delta, lon_delta;
	logic      lat_rad_finish, lon_rad_finish;
	rad_prod_t lat_rad, lon_rad;
	logic      lat_sq_finish, lon_sq_finish;
	sq_term_t  lat_sq, lon_sq;
	logic      lon_cos_a_finish;
	lon_term_t lon_cos_a;

	gps_dist_ctrl u_ctrl (
		.clk              (clk),
		.reset_n          (reset_n),
		.den              (den),
		.lat_in           (lat_in),
		.lon_in           (lon_in),
		.cos_finish       (cos_finish),
		.cos_value        (cos_value),
		.lat_sq_finish    (lat_sq_finish),
		.lat_sq           (lat_sq),
		.lon_cos_a_finish (lon_cos_a_finish),
		.lon_cos_a        (lon_cos_a),
		.cos_start        (cos_start),
		.cos_lat          (cos_lat),
		.delta_start      (delta_start),
		.lat_delta        (lat_delta),
		.lon_delta        (lon_delta),
		.cos_a            (cos_a),
		.valid            (valid),
		.a                (a)
	);

	cos_interp u_cos (
		.clk      (clk),
		.reset_n  (reset_n),
		.start    (cos_start),
		.lat      (cos_lat),
		.cos_data (cos_data),
		.cos_addr (cos_addr),
		.finish   (cos_finish),
		.value    (cos_value)
	);

	// latitude path, delta in radians then half squared
	shift_add_mult #(.multiplicand_size(6), .multiplier_size(11)) lat_rad_mult (
		.clk (clk), .reset_n (reset_n), .start (delta_start),
		.multiplicand (lat_delta), .multiplier (RAD_PER_UNIT),
		.finish (lat_rad_finish), .product (lat_rad)
	);

	shift_add_mult #(.multiplicand_size(15), .multiplier_size(15)) lat_sq_mult (
		.clk (clk), .reset_n (reset_n), .start (lat_rad_finish),
		.multiplicand (lat_rad[15:1]), .multiplier (lat_rad[15:1]),
		.finish (lat_sq_finish), .product (lat_sq)
	);

	// longitude path, same again and scaled by cos(latA)
	shift_add_mult #(.multiplicand_size(6), .multiplier_size(11)) lon_rad_mult (
		.clk (clk), .reset_n (reset_n), .start (delta_start),
		.multiplicand (lon_delta), .multiplier (RAD_PER_UNIT),
		.finish (lon_rad_finish), .product (lon_rad)
	);

	shift_add_mult #(.multiplicand_size(15), .multiplier_size(15)) lon_sq_mult (
		.clk (clk), .reset_n (reset_n), .start (lon_rad_finish),
		.multiplicand (lon_rad[15:1]), .multiplier (lon_rad[15:1]),
		.finish (lon_sq_finish), .product (lon_sq)
	);

	shift_add_mult #(.multiplicand_size(30), .multiplier_size(64)) lon_cos_a_mult (
		.clk (clk), .reset_n (reset_n), .start (lon_sq_finish),
		.multiplicand (lon_sq), .multiplier (cos_a),
		.finish (lon_cos_a_finish), .product (lon_cos_a)
	);

endmodule

`default_nettype wire

//--- gps_dist_properties.sv
`default_nettype none

module gps_dist_properties import gps_pkg::*; (
	input wire             clk,
	input wire             reset_n,
	input wire             valid,
	input wire haversine_t a,
	input wire             delta_start,
	input wire             lon_cos_a_finish,
	input wire             cos_finish
);

	timeunit 1ns;
	timeprecision 100ps;

	logic lon_term_pending; // deltas started, lon term not captured yet

	always_ff @(posedge clk) begin
		if (!reset_n)
			lon_term_pending <= 1'b0;
		else if (delta_start)
			lon_term_pending <= 1'b1;
		else if (lon_cos_a_finish)
			lon_term_pending <= 1'b0;
	end

	valid_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		valid |=> !valid)
		else $error("valid stayed high for two cycles");

	a_known_when_valid: assert property (@(posedge clk) disable iff (!reset_n)
		valid |-> !$isunknown(a))
		else $error("a has unknown bits while valid is high");

	valid_low_in_reset: assert property (@(posedge clk)
		!reset_n |=> !valid)
		else $error("valid high after a reset cycle");

	// cos(latA) product has to be in before the new cosine finishes
	lon_term_before_cos: assert property (@(posedge clk) disable iff (!reset_n)
		cos_finish |-> !lon_term_pending)
		else $error("cosine finished before the longitude term was captured");

endmodule

`default_nettype wire

//--- tb_gps_dist.sv
`default_nettype none

module tb_gps_dist import gps_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic       clk;
	logic       reset_n;
	logic       den;
	coord_t     lat_in;
	coord_t     lon_in;
	cos_addr_t  cos_addr;
	cos_word_t  cos_data;
	logic       valid;
	haversine_t a;

	cos_key_t    table_key [COS_DEPTH];
	cos_val_t    table_val [COS_DEPTH];
	logic [31:0] lcg_state;
	coord_t      prev_lat, prev_lon; // last accepted fix
	haversine_t  expected_q [$];
	int          pushed;
	int          checked;

	gps_dist_top DUT (
		.clk      (clk),
		.reset_n  (reset_n),
		.den      (den),
		.lat_in   (lat_in),
		.lon_in   (lon_in),
		.cos_addr (cos_addr),
		.cos_data (cos_data),
		.valid    (valid),
		.a        (a)
	);

	bind gps_dist_top gps_dist_properties props (
		.clk              (clk),
		.reset_n          (reset_n),
		.valid            (valid),
		.a                (a),
		.delta_start      (delta_start),
		.lon_cos_a_finish (lon_cos_a_finish),
		.cos_finish       (cos_finish)
	);

	always #4 clk = ~clk;

	// combinational table read
	assign cos_data = {20'b0, table_key[cos_addr], 16'b0, table_val[cos_addr]};

	function automatic void build_table();
		logic [63:0] kspan, vspan, k;
		kspan = 64'(COS_LAST_KEY - COS_FIRST_KEY);
		vspan = 64'(COS_LAST_VAL - COS_FIRST_VAL);
		for (int i = 0; i < COS_DEPTH; i++) begin
			k = 64'(COS_FIRST_KEY) + kspan * i / (COS_DEPTH - 1);
			table_key[i] = {k[27:16], 16'h0000}; // interior keys on whole lat codes
			table_val[i] = COS_FIRST_VAL + cos_val_t'(vspan * i / (COS_DEPTH - 1));
		end
		table_key[0]           = COS_FIRST_KEY;
		table_key[COS_DEPTH-1] = COS_LAST_KEY;
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// table bracket, then (yl*t1 + t3*t2) * 2^32 / t1
	function automatic cosine_t interp_cos(input lat_t lat);
		cos_key_t    key, xl, xr;
		cos_val_t    yl, yr;
		logic [18:0] t1, t2;
		logic [17:0] t3;
		logic [83:0] num, quo;
		int          lo;
		key = {lat, 16'b0};
		lo  = 0;
		for (int i = 0; i < COS_DEPTH - 1; i++)
			if (table_key[i] <= key)
				lo = i;
		xl  = table_key[lo];
		xr  = table_key[lo+1];
		yl  = table_val[lo];
		yr  = table_val[lo+1];
		t1  = 19'(xr - xl);
		t2  = 19'(key - xl);
		t3  = 18'(yr - yl);
		num = 84'(yl) * 84'(t1) + 84'(t3) * 84'(t2);
		quo = (num << 32) / 84'(t1);
		return quo[63:0];
	endfunction

	function automatic haversine_t ref_haversine(input coord_t lat_a, input coord_t lon_a,
			input coord_t lat_b, input coord_t lon_b);
		logic [11:0]  la, lb, dlat;
		logic [23:0]  dlon;
		logic [16:0]  lat_rad, lon_rad;
		logic [29:0]  lat_sq, lon_sq;
		logic [157:0] lon_term, prod;
		la       = lat_a[11:0];
		lb       = lat_b[11:0];
		dlat     = (la >= lb) ? la - lb : lb - la;
		dlon     = (lon_a >= lon_b) ? lon_a - lon_b : lon_b - lon_a;
		lat_rad  = 17'(dlat[5:0]) * 17'(RAD_PER_UNIT);
		lon_rad  = 17'(dlon[5:0]) * 17'(RAD_PER_UNIT);
		lat_sq   = 30'(lat_rad[15:1]) * 30'(lat_rad[15:1]); // half angle squared
		lon_sq   = 30'(lon_rad[15:1]) * 30'(lon_rad[15:1]);
		lon_term = 158'(lon_sq) * 158'(interp_cos(la));
		prod     = lon_term * 158'(interp_cos(lb));
		return lat_sq + prod[157:128];
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic random_fix(output coord_t lat, output coord_t lon);
		logic [31:0] r;
		lat_t        lo, hi;
		lo  = COS_FIRST_KEY[27:16] + 1'b1; // first whole code above entry 0
		hi  = COS_LAST_KEY[27:16];
		r   = lcg_next();
		lat = {r[15:4], lo + lat_t'(r[31:16] % (hi - lo + 1'b1))};
		r   = lcg_next();
		lon = r[31:8];
	endtask

	task automatic drive_fix(input coord_t lat, input coord_t lon);
		@(negedge clk);
		den    = 1'b1;
		lat_in = lat;
		lon_in = lon;
		@(negedge clk);
		den = 1'b0;
	endtask

	task automatic expect_quiet(input int cycles, input string why);
		repeat (cycles) begin
			@(negedge clk);
			assert (!valid) else fail_run({"valid pulse seen ", why});
		end
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		@(negedge clk);
		while (!valid) begin
			n++;
			if (n > 1000)
				fail_run("no valid within 1000 cycles of an accepted fix");
			@(negedge clk);
		end
	endtask

	// noise dens land while the fix is in flight
	task automatic run_fix(input coord_t lat, input coord_t lon, input int noise);
		coord_t nlat, nlon;
		expected_q.push_back(ref_haversine(prev_lat, prev_lon, lat, lon));
		pushed++;
		drive_fix(lat, lon);
		prev_lat = lat;
		prev_lon = lon;
		for (int k = 0; k < noise; k++) begin
			expect_quiet(20, "while a fix is in flight");
			random_fix(nlat, nlon);
			drive_fix(nlat, nlon);
		end
		wait_valid();
	endtask

	task automatic run_key_fix(input int idx);
		coord_t lat, lon;
		random_fix(lat, lon);
		lat[11:0] = table_key[idx][27:16]; // t2 is zero
		run_fix(lat, lon, 0);
	endtask

	always @(negedge clk) begin : compare_valid
		haversine_t exp_a;
		if (reset_n && valid) begin
			assert (expected_q.size() != 0)
				else fail_run("valid pulse with no accepted fix outstanding");
			if (expected_q.size() != 0) begin
				exp_a = expected_q.pop_front();
				checked++;
				assert (a === exp_a)
					else fail_run($sformatf("ERR %0t a expected %h got %h", $time, exp_a, a));
			end
		end
	end

	initial begin
		coord_t fix_lat, fix_lon;
		clk       = 1'b0;
		reset_n   = 1'b0;
		den       = 1'b0;
		lat_in    = '0;
		lon_in    = '0;
		lcg_state = 32'd39;
		pushed    = 0;
		checked   = 0;
		build_table();
		repeat (16) @(negedge clk);
		reset_n = 1'b1;

		expect_quiet(50, "before the first fix");

		// first fix only becomes the reference
		random_fix(fix_lat, fix_lon);
		drive_fix(fix_lat, fix_lon);
		prev_lat = fix_lat;
		prev_lon = fix_lon;
		expect_quiet(20, "after the first fix");
		random_fix(fix_lat, fix_lon);
		drive_fix(fix_lat, fix_lon); // still in FIRST_WAIT
		expect_quiet(400, "after the first fix");

		repeat (40) begin
			random_fix(fix_lat, fix_lon);
			run_fix(fix_lat, fix_lon, 0);
		end

		run_fix(prev_lat, prev_lon, 0);
		assert (a === '0)
			else fail_run($sformatf("ERR %0t a expected %h got %h", $time, haversine_t'(0), a));

		repeat (3) begin
			random_fix(fix_lat, fix_lon);
			run_fix(fix_lat, fix_lon, 3);
		end

		run_key_fix(1);
		run_key_fix(COS_MID_ADDR);
		run_key_fix(COS_DEPTH - 2);

		expect_quiet(50, "after the last fix");
		if (expected_q.size() == 0 && checked == pushed) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("%0d results expected, %0d checked", pushed, checked);
			$display("=== FAIL ===");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- compile.f
gps_pkg.sv
shift_add_mult.sv
restoring_div.sv
cos_interp.sv
gps_dist_ctrl.sv
gps_dist_top.sv
gps_dist_properties.sv
tb_gps_dist.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       := tb_gps_dist
FILELIST  := compile.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
